// File: Makefile
SIM      = verilator
SIMFLAGS = --binary --timing --assert -j 0
TOP      = download_tb
FILELIST = download.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: download.f
+incdir+rtl
rtl/msx_pkg.sv
rtl/store_msx_config.sv
rtl/upload_ram.sv
rtl/download.sv
sim/tb_clock.sv
sim/ddr3_model.sv
sim/download_tb.sv

// File: rtl/download.sv
`timescale 1ns/1ps
`default_nettype none

`include "download_config.svh"

module download
(
   input  wire                  clk,
   input  wire                  arst_n,
   input  wire                  ioctl_download,
   input  wire           [15:0] ioctl_index,
   input  wire            [7:0] ddr3_dout,
   input  wire                  ddr3_ready,
   input  wire                  sdram_ready,
   output logic          [27:0] ddr3_addr,
   output logic                 ddr3_rd,
   output logic                 ddr3_request,
   output logic          [24:0] sdram_addr,
   output logic           [7:0] sdram_din,
   output logic                 sdram_we,
   output logic                 sdram_request,
   output logic                 need_reset,
   output logic                 msx_type,
   output msx_pkg::slot_t       msx_slot[`DL_SLOTS],
   output msx_pkg::block_t      memory_block[`DL_SLOTS],
   output logic           [7:0] ram_block_count
);

   logic        dl_q;
   logic        cfg_start, cfg_done;
   logic        ram_start, ram_done;
   logic        cfg_ddr3_rd,      ram_ddr3_rd;
   logic        cfg_ddr3_request, ram_ddr3_request;
   logic [27:0] cfg_ddr3_addr,    ram_ddr3_addr;

   // Config reader has priority on the shared DDR3 port
   assign ddr3_addr    = cfg_ddr3_request ? cfg_ddr3_addr :
                         ram_ddr3_request ? ram_ddr3_addr :
                                            28'd0;
   assign ddr3_rd      = cfg_ddr3_request ? cfg_ddr3_rd   :
                         ram_ddr3_request ? ram_ddr3_rd   :
                                            1'b0;
   assign ddr3_request = cfg_ddr3_request | ram_ddr3_request;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dl_q       <= 1'b0;
         cfg_start  <= 1'b0;
         ram_start  <= 1'b0;
         need_reset <= 1'b0;
      end else begin
         dl_q       <= ioctl_download;
         // Only the end of a config download starts the loader
         cfg_start  <= dl_q && !ioctl_download && (ioctl_index == `DL_CONFIG_INDEX);
         ram_start  <= cfg_done;   // Copy as soon as the slot table is out
         need_reset <= ram_done;
      end
   end

   store_msx_config store_msx_config_i
   (
      .start(cfg_start),
      .ddr3_addr(cfg_ddr3_addr),
      .ddr3_rd(cfg_ddr3_rd),
      .ddr3_request(cfg_ddr3_request),
      .done(cfg_done),
      .*
   );

   upload_ram upload_ram_i
   (
      .start(ram_start),
      .ddr3_addr(ram_ddr3_addr),
      .ddr3_rd(ram_ddr3_rd),
      .ddr3_request(ram_ddr3_request),
      .done(ram_done),
      .*
   );

   a_single_owner: assert property (@(posedge clk) disable iff (!arst_n)
      !(cfg_ddr3_request && ram_ddr3_request));

endmodule

`default_nettype wire

// File: rtl/download_config.svh
`ifndef DOWNLOAD_CONFIG_SVH
`define DOWNLOAD_CONFIG_SVH

// Download index that carries the machine configuration
`define DL_CONFIG_INDEX 16'd0

// DDR3 location of the five byte configuration record
`define DL_CONFIG_BASE 28'h000_0000

// ROM image of slot 0 and the spacing to the image of each further slot
`define DL_ROM_BASE   28'h000_1000
`define DL_ROM_STRIDE 28'h000_1000

// Small blocks keep the copy short
`define DL_BLOCK_BYTES 16

`define DL_SLOTS 4

`endif

// File: rtl/msx_pkg.sv
`default_nettype none

package msx_pkg;

   // Kind of content mapped into a slot
   typedef enum logic [1:0] {
      DEV_NONE = 2'd0,
      DEV_RAM  = 2'd1,
      DEV_ROM  = 2'd2
   } device_t;

   // One record byte with the device kind on top and the image size in blocks below
   typedef struct packed {
      device_t    device;     // Bits 7 and 6
      logic       reserved;   // Bit 5 is ignored by the loader
      logic [4:0] size;       // 0 to 31 blocks
   } slot_t;

   // Placement of one copied ROM image in SDRAM
   typedef struct packed {
      logic [7:0] base;       // First SDRAM block of the image
      logic [4:0] count;      // Number of blocks copied
      logic       valid;
   } block_t;

endpackage

`default_nettype wire

// File: rtl/store_msx_config.sv
`timescale 1ns/1ps
`default_nettype none

`include "download_config.svh"

module store_msx_config
(
   input  wire                  clk,
   input  wire                  arst_n,
   input  wire                  start,
   input  wire            [7:0] ddr3_dout,
   input  wire                  ddr3_ready,
   output logic          [27:0] ddr3_addr,
   output logic                 ddr3_rd,
   output logic                 ddr3_request,
   output logic                 msx_type,
   output msx_pkg::slot_t       msx_slot[`DL_SLOTS],
   output logic                 done
);

   import msx_pkg::*;

   localparam int REC_BYTES = `DL_SLOTS + 1;   // Machine type followed by one byte per slot
   localparam int CNT_W     = $clog2(REC_BYTES);
   localparam int SLOT_W    = $clog2(`DL_SLOTS);

   typedef enum logic [1:0] {
      S_IDLE,
      S_ISSUE,
      S_WAIT,
      S_PUBLISH
   } state_t;

   state_t           state;
   logic [CNT_W-1:0] byte_cnt;
   logic       [7:0] type_shadow;
   slot_t            slot_shadow[`DL_SLOTS];

   // Counter only moves after a read completes, so the address holds while rd waits
   assign ddr3_addr = `DL_CONFIG_BASE + 28'(byte_cnt);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state        <= S_IDLE;
         byte_cnt     <= '0;
         ddr3_rd      <= 1'b0;
         ddr3_request <= 1'b0;
         msx_type     <= 1'b0;
         msx_slot     <= '{default: '0};
         done         <= 1'b0;
      end else begin
         done <= 1'b0;
         case (state)
            S_IDLE: begin
               if (start) begin
                  byte_cnt     <= '0;
                  ddr3_request <= 1'b1;   // Own the port for the whole record
                  state        <= S_ISSUE;
               end
            end
            S_ISSUE: begin
               ddr3_rd <= 1'b1;
               state   <= S_WAIT;
            end
            S_WAIT: begin
               if (ddr3_ready) begin
                  ddr3_rd <= 1'b0;
                  if (byte_cnt == CNT_W'(REC_BYTES - 1)) begin
                     state <= S_PUBLISH;
                  end else begin
                     byte_cnt <= byte_cnt + 1'b1;
                     state    <= S_ISSUE;
                  end
               end
            end
            S_PUBLISH: begin
               // The whole table changes in one cycle together with done
               msx_type     <= (type_shadow == 8'd0);
               msx_slot     <= slot_shadow;
               ddr3_request <= 1'b0;
               done         <= 1'b1;
               state        <= S_IDLE;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_WAIT && ddr3_ready) begin
         if (byte_cnt == '0)
            type_shadow <= ddr3_dout;
         else
            slot_shadow[SLOT_W'(byte_cnt - 1'b1)] <= slot_t'(ddr3_dout);
      end
   end

   // A pending read keeps its address until the memory answers
   a_addr_hold: assert property (@(posedge clk) disable iff (!arst_n)
      ddr3_rd && !ddr3_ready |=> ddr3_rd && $stable(ddr3_addr));

endmodule

`default_nettype wire

// File: rtl/upload_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "download_config.svh"

module upload_ram
(
   input  wire                  clk,
   input  wire                  arst_n,
   input  wire                  start,
   input  wire  msx_pkg::slot_t msx_slot[`DL_SLOTS],
   input  wire            [7:0] ddr3_dout,
   input  wire                  ddr3_ready,
   input  wire                  sdram_ready,
   output logic          [27:0] ddr3_addr,
   output logic                 ddr3_rd,
   output logic                 ddr3_request,
   output logic          [24:0] sdram_addr,
   output logic           [7:0] sdram_din,
   output logic                 sdram_we,
   output logic                 sdram_request,
   output msx_pkg::block_t      memory_block[`DL_SLOTS],
   output logic           [7:0] ram_block_count,
   output logic                 done
);

   import msx_pkg::*;

   localparam int SLOT_W = $clog2(`DL_SLOTS);
   localparam int CNT_W  = $clog2(31 * `DL_BLOCK_BYTES + 1);   // Largest image in bytes

   typedef enum logic [2:0] {
      S_IDLE,
      S_SLOT,
      S_ISSUE,
      S_READ,
      S_WRITE,
      S_NEXT
   } state_t;

   state_t            state;
   logic [SLOT_W-1:0] slot_idx;
   logic  [CNT_W-1:0] bytes_left;
   slot_t             cur_slot;

   assign cur_slot = msx_slot[slot_idx];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state           <= S_IDLE;
         slot_idx        <= '0;
         bytes_left      <= '0;
         ddr3_addr       <= '0;
         ddr3_rd         <= 1'b0;
         ddr3_request    <= 1'b0;
         sdram_addr      <= '0;
         sdram_we        <= 1'b0;
         sdram_request   <= 1'b0;
         memory_block    <= '{default: '0};
         ram_block_count <= '0;
         done            <= 1'b0;
      end else begin
         done <= 1'b0;
         case (state)
            S_IDLE: begin
               if (start) begin
                  slot_idx        <= '0;
                  sdram_addr      <= '0;   // First image lands at the bottom of SDRAM
                  ram_block_count <= '0;
                  ddr3_request    <= 1'b1;
                  sdram_request   <= 1'b1;
                  state           <= S_SLOT;
               end
            end
            S_SLOT: begin
               ddr3_addr  <= `DL_ROM_BASE + 28'(slot_idx) * `DL_ROM_STRIDE;
               bytes_left <= CNT_W'(cur_slot.size * `DL_BLOCK_BYTES);
               if (cur_slot.device == DEV_ROM) begin
                  // Next free block is the running total so far
                  memory_block[slot_idx] <= '{base: ram_block_count, count: cur_slot.size,
                                              valid: 1'b1};
                  ram_block_count        <= ram_block_count + 8'(cur_slot.size);
                  state                  <= (cur_slot.size != 5'd0) ? S_ISSUE : S_NEXT;
               end else begin
                  memory_block[slot_idx] <= '0;
                  state                  <= S_NEXT;
               end
            end
            S_ISSUE: begin
               ddr3_rd <= 1'b1;
               state   <= S_READ;
            end
            S_READ: begin
               if (ddr3_ready) begin
                  ddr3_rd  <= 1'b0;
                  sdram_we <= 1'b1;   // Byte moves straight on to SDRAM
                  state    <= S_WRITE;
               end
            end
            S_WRITE: begin
               if (sdram_ready) begin
                  sdram_we   <= 1'b0;
                  sdram_addr <= sdram_addr + 25'd1;
                  ddr3_addr  <= ddr3_addr + 28'd1;
                  bytes_left <= bytes_left - 1'b1;
                  state      <= (bytes_left == CNT_W'(1)) ? S_NEXT : S_ISSUE;
               end
            end
            S_NEXT: begin
               if (slot_idx == SLOT_W'(`DL_SLOTS - 1)) begin
                  ddr3_request  <= 1'b0;
                  sdram_request <= 1'b0;
                  done          <= 1'b1;
                  state         <= S_IDLE;
               end else begin
                  slot_idx <= slot_idx + 1'b1;
                  state    <= S_SLOT;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_READ && ddr3_ready)
         sdram_din <= ddr3_dout;
   end

   // Only one byte is ever in flight
   a_one_in_flight: assert property (@(posedge clk) disable iff (!arst_n)
      !(sdram_we && ddr3_rd));

   a_write_hold: assert property (@(posedge clk) disable iff (!arst_n)
      sdram_we && !sdram_ready |=> sdram_we && $stable(sdram_din) && $stable(sdram_addr));

endmodule

`default_nettype wire

// File: sim/ddr3_model.sv
`timescale 1ns/1ps
`default_nettype none

module ddr3_model (
   input  wire        clk,
   input  wire        arst_n,
   input  wire [27:0] ddr3_addr,
   input  wire        ddr3_rd,
   output wire  [7:0] ddr3_dout,
   output wire        ddr3_ready
);

   logic [7:0] mem [logic [27:0]];   // Filled by the testbench before each download
   logic       ready_q     = 1'b0;
   logic [7:0] dout_q      = 8'h00;
   int         wait_cycles = -1;      // Negative while no read is pending

   assign ddr3_ready = ready_q;
   assign ddr3_dout  = dout_q;

   always @(negedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ready_q     <= 1'b0;
         wait_cycles = -1;
      end else if (ready_q) begin
         ready_q <= 1'b0;   // The read was taken on the last rising edge
      end else if (ddr3_rd) begin
         if (wait_cycles < 0)
            wait_cycles = int'($urandom_range(3));
         if (wait_cycles == 0) begin
            ready_q <= 1'b1;
            dout_q  <= mem.exists(ddr3_addr) ? mem[ddr3_addr] : 8'hxx;
         end
         wait_cycles = wait_cycles - 1;
      end
   end

endmodule

`default_nettype wire

// File: sim/download_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "download_config.svh"

module download_tb;

   import msx_pkg::*;

   localparam int SLOT_BITS = `DL_SLOTS * 8;
   localparam int BLK_W     = $bits(block_t);
   localparam int BLK_BITS  = `DL_SLOTS * BLK_W;
   // Worst case is every slot a 31 block ROM with both memories slow, about 12 cycles a byte
   localparam int WORST_DL    = 60 + `DL_SLOTS * (31 * `DL_BLOCK_BYTES * 12 + 4);
   localparam int CYCLE_LIMIT = 4 * (100 + 2 * WORST_DL);

   logic                 clk;
   logic                 arst_n         = 1'b0;
   logic                 ioctl_download = 1'b0;
   logic          [15:0] ioctl_index    = 16'd0;
   logic                 sdram_ready    = 1'b0;
   wire            [7:0] ddr3_dout;
   wire                  ddr3_ready;
   logic          [27:0] ddr3_addr;
   logic                 ddr3_rd, ddr3_request;
   logic          [24:0] sdram_addr;
   logic           [7:0] sdram_din;
   logic                 sdram_we, sdram_request, need_reset, msx_type;
   slot_t                msx_slot[`DL_SLOTS];
   block_t               memory_block[`DL_SLOTS];
   logic           [7:0] ram_block_count;
   logic [SLOT_BITS-1:0] slot_bits, exp_slot_bits;
   logic  [BLK_BITS-1:0] blk_bits, exp_blk_bits;
   logic                 exp_type;
   logic           [7:0] exp_blocks, exp_din;
   logic          [24:0] exp_addr;
   logic           [7:0] exp_data[$];          // Every byte SDRAM should see, in order
   logic           [7:0] ddr3_copy[logic [27:0]];
   int err_cnt = 0, wr_cnt = 0, wr_base = 0, exp_total = 0, cfg_cnt = 0, nr_cnt = 0;
   int cycles = 0, sd_wait = -1, tests_passed = 0, tests_failed = 0;

   tb_clock clock_i (.clk(clk));

   ddr3_model ddr3_model_i (.clk, .arst_n, .ddr3_addr, .ddr3_rd, .ddr3_dout, .ddr3_ready);

   download dut_i (
      .clk, .arst_n, .ioctl_download, .ioctl_index, .ddr3_dout, .ddr3_ready, .sdram_ready,
      .ddr3_addr, .ddr3_rd, .ddr3_request, .sdram_addr, .sdram_din, .sdram_we,
      .sdram_request, .need_reset, .msx_type, .msx_slot, .memory_block, .ram_block_count
   );

   for (genvar i = 0; i < `DL_SLOTS; i++) begin : g_pack
      assign slot_bits[i*8 +: 8]        = msx_slot[i];
      assign blk_bits[i*BLK_W +: BLK_W] = memory_block[i];
   end

   // SDRAM side answers each write after 0 to 3 idle cycles
   always @(negedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sdram_ready <= 1'b0;
         sd_wait     = -1;
      end else if (sdram_ready) begin
         sdram_ready <= 1'b0;
      end else if (sdram_we) begin
         if (sd_wait < 0)
            sd_wait = int'($urandom_range(3));
         if (sd_wait == 0)
            sdram_ready <= 1'b1;
         sd_wait = sd_wait - 1;
      end
   end

   always @(negedge clk) begin
      exp_addr <= 25'(wr_cnt - wr_base);   // Each download copies from SDRAM address 0
      exp_din  <= (wr_cnt < exp_total) ? exp_data[wr_cnt] : 8'h00;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (need_reset)
         nr_cnt <= nr_cnt + 1;
      if (arst_n && sdram_we && sdram_ready)
         wr_cnt <= wr_cnt + 1;
      if (cycles == CYCLE_LIMIT) begin
         $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   task automatic report_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
      $display("error: %s %0h expected %0h", name, got, exp);
      err_cnt++;
   endtask

   task automatic report_failure(input string what);
      $display("%s", what);
      err_cnt++;
   endtask

   a_quiet_ctrl: assert property (@(posedge clk) disable iff (!arst_n)
      cfg_cnt == 0 |-> {ddr3_rd, ddr3_request, sdram_we, sdram_request, need_reset} == 5'd0)
      else report_value("ddr3_rd,ddr3_request,sdram_we,sdram_request,need_reset",
                        64'($sampled({ddr3_rd, ddr3_request, sdram_we, sdram_request,
                                      need_reset})), 0);
   a_quiet_count: assert property (@(posedge clk) disable iff (!arst_n)
      cfg_cnt == 0 |-> ram_block_count == 8'd0)
      else report_value("ram_block_count", 64'($sampled(ram_block_count)), 0);
   a_ddr3_owner: assert property (@(posedge clk) disable iff (!arst_n)
      ddr3_rd |-> ddr3_request)
      else report_failure("ddr3_rd was high while ddr3_request was low");
   a_sdram_owner: assert property (@(posedge clk) disable iff (!arst_n)
      sdram_we |-> sdram_request)
      else report_failure("sdram_we was high while sdram_request was low");
   a_ddr3_hold: assert property (@(posedge clk) disable iff (!arst_n)
      ddr3_rd && !ddr3_ready |=> ddr3_rd && $stable(ddr3_addr))
      else report_failure("ddr3_rd dropped or ddr3_addr moved before ddr3_ready");
   a_sdram_hold: assert property (@(posedge clk) disable iff (!arst_n)
      sdram_we && !sdram_ready |=> sdram_we && $stable(sdram_addr) && $stable(sdram_din))
      else report_failure("sdram_we dropped or its address or data moved before sdram_ready");
   a_write_extra: assert property (@(posedge clk) disable iff (!arst_n)
      sdram_we && sdram_ready |-> wr_cnt < exp_total)
      else report_failure("SDRAM write beyond the images that the slot table asks for");
   a_write_addr: assert property (@(posedge clk) disable iff (!arst_n)
      sdram_we && sdram_ready |-> sdram_addr == exp_addr)
      else report_value("sdram_addr", 64'($sampled(sdram_addr)), 64'($sampled(exp_addr)));
   a_write_data: assert property (@(posedge clk) disable iff (!arst_n)
      sdram_we && sdram_ready |-> sdram_din == exp_din)
      else report_value("sdram_din", 64'($sampled(sdram_din)), 64'($sampled(exp_din)));
   a_type: assert property (@(posedge clk) disable iff (!arst_n)
      need_reset |-> msx_type == exp_type)
      else report_value("msx_type", 64'(msx_type), 64'(exp_type));
   a_slot: assert property (@(posedge clk) disable iff (!arst_n)
      need_reset |-> slot_bits == exp_slot_bits)
      else report_value("msx_slot", 64'(slot_bits), 64'(exp_slot_bits));
   a_blocks: assert property (@(posedge clk) disable iff (!arst_n)
      need_reset |-> blk_bits == exp_blk_bits)
      else report_value("memory_block", 64'(blk_bits), 64'(exp_blk_bits));
   a_count: assert property (@(posedge clk) disable iff (!arst_n)
      need_reset |-> ram_block_count == exp_blocks)
      else report_value("ram_block_count", 64'(ram_block_count), 64'(exp_blocks));
   a_writes: assert property (@(posedge clk) disable iff (!arst_n)
      need_reset |-> wr_cnt - wr_base == int'(ram_block_count) * `DL_BLOCK_BYTES)
      else report_value("SDRAM write count", 64'(wr_cnt - wr_base),
                        64'(int'(ram_block_count) * `DL_BLOCK_BYTES));
   a_reset_once: assert property (@(posedge clk) disable iff (!arst_n)
      need_reset |-> nr_cnt + 1 == cfg_cnt)
      else report_failure("need_reset pulsed without a pending configuration download");

   // Writes a fresh record and ROM images into DDR3 and works out the results they lead to
   task automatic load_image(input bit first);
      logic  [7:0] rec0;
      logic  [7:0] total;
      logic  [7:0] b;
      logic [27:0] addr;
      slot_t       sb;
      block_t      blk;
      rec0  = first ? 8'd0 : 8'($urandom_range(255, 1));   // Both machine types get a turn
      total = 8'd0;
      ddr3_model_i.mem[`DL_CONFIG_BASE] = rec0;
      exp_type = (rec0 == 8'd0);
      for (int s = 0; s < `DL_SLOTS; s++) begin
         sb.device   = (s == 0) ? DEV_ROM : device_t'(2'($urandom_range(2)));
         sb.reserved = 1'($urandom);
         sb.size     = 5'($urandom);
         ddr3_model_i.mem[`DL_CONFIG_BASE + 28'(s + 1)] = sb;
         exp_slot_bits = {sb, exp_slot_bits[SLOT_BITS-1:8]};
         for (int o = 0; o < 31 * `DL_BLOCK_BYTES; o++) begin
            addr = `DL_ROM_BASE + 28'(s) * `DL_ROM_STRIDE + 28'(o);
            b    = 8'($urandom);
            ddr3_model_i.mem[addr] = b;
            ddr3_copy[addr]        = b;
         end
         blk = '0;
         if (sb.device == DEV_ROM) begin
            blk = '{base: total, count: sb.size, valid: 1'b1};
            for (int o = 0; o < int'(sb.size) * `DL_BLOCK_BYTES; o++)
               exp_data.push_back(ddr3_copy[`DL_ROM_BASE + 28'(s) * `DL_ROM_STRIDE + 28'(o)]);
            total = total + 8'(sb.size);
         end
         exp_blk_bits = {blk, exp_blk_bits[BLK_BITS-1:BLK_W]};
      end
      exp_blocks = total;
      exp_total  = exp_data.size();
   endtask

   task automatic run_download(input logic [15:0] index);
      @(negedge clk);
      ioctl_index    = index;
      ioctl_download = 1'b1;
      repeat (4) @(negedge clk);
      ioctl_download = 1'b0;
   endtask

   task automatic report_test(input string name, input int errs_before);
      if (err_cnt == errs_before) begin
         tests_passed++;
         $display("test %s passed", name);
      end else begin
         tests_failed++;
         $display("test %s failed with %0d errors", name, err_cnt - errs_before);
      end
   endtask

   initial begin
      int errs;
      void'($urandom(79));
      repeat (10) @(negedge clk);
      arst_n = 1'b1;
      errs   = err_cnt;
      repeat (20) @(negedge clk);
      report_test("reset_quiet", errs);
      errs = err_cnt;
      run_download(16'd3);   // Some other index that the loader must ignore
      repeat (50) @(negedge clk);
      report_test("foreign_index", errs);
      for (int n = 1; n <= 2; n++) begin
         errs = err_cnt;
         load_image(n == 1);
         wr_base = wr_cnt;
         cfg_cnt++;
         run_download(`DL_CONFIG_INDEX);
         @(posedge clk iff need_reset);
         @(negedge clk);
         report_test($sformatf("config_download_%0d", n), errs);
      end
      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               tests_passed + tests_failed, tests_passed, tests_failed, err_cnt);
      if (tests_failed == 0 && err_cnt == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter int PERIOD_NS = 100
) (
   output logic clk
);

   initial clk = 1'b0;

   always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire
